//--- common/prof_defs.svh
// cache profiler global parameters
// widths and sizes shared by the counter bank, snapshot FIFO and dumper

`ifndef PROF_DEFS_SVH
`define PROF_DEFS_SVH

// cache data word and the store byte mask derived from it
`define PROF_DATA_W 32
`define PROF_MASK_W (`PROF_DATA_W / 8)

// counter bank
`define PROF_CTR_W 32
`define PROF_NUM_CTRS 18

// snapshot tagging and buffering
`define PROF_TAG_W 8
`define PROF_FIFO_DEPTH 2

`endif

//--- common/cache_op_pkg.sv
// cache operation types
// decoded opcode, access size and store byte mask as seen by the profiler

`default_nettype none

`include "prof_defs.svh"

package cache_op_pkg;

  // accepted cache operation, one code per decoded op
  typedef enum logic [3:0] {
    ld      = 4'd0,
    st      = 4'd1,
    tagst   = 4'd2,  // tag store
    tagfl   = 4'd3,  // tag flush
    taglv   = 4'd4,  // tag load valid
    tagla   = 4'd5,  // tag load address
    afl     = 4'd6,  // address flush
    aflinv  = 4'd7,  // address flush invalidate
    ainv    = 4'd8,  // address invalidate
    alock   = 4'd9,
    aunlock = 4'd10,
    amoswap = 4'd11,
    amoor   = 4'd12
  } cache_op_t;

  // load data size, same encoding as the cache decode field
  // byte is a keyword, hence the sz_ prefix
  typedef enum logic [1:0] {
    sz_byte = 2'b00,
    sz_half = 2'b01,
    sz_word = 2'b10
  } access_size_t;

  // one bit per data byte of a store
  typedef logic [`PROF_MASK_W-1:0] byte_mask_t;

endpackage

`default_nettype wire

//--- common/prof_pkg.sv
// profiler types
// counter values, counter slot names, snapshot tag and dumper states

`default_nettype none

`include "prof_defs.svh"

package prof_pkg;

  typedef logic [`PROF_CTR_W-1:0] ctr_t;
  typedef logic [`PROF_TAG_W-1:0] stat_tag_t;

  // counter slot order, also the dump order
  typedef enum logic [4:0] {
    ld_total    = 5'd0,
    ld_word     = 5'd1,
    ld_half     = 5'd2,
    ld_byte     = 5'd3,
    ld_unsigned = 5'd4,
    st_total    = 5'd5,
    st_word     = 5'd6,
    st_half     = 5'd7,
    st_byte     = 5'd8,
    tag_op      = 5'd9,
    addr_op     = 5'd10,
    atomic_op   = 5'd11,
    miss_ld     = 5'd12,
    miss_st     = 5'd13,
    miss_cycle  = 5'd14,
    idle_cycle  = 5'd15,
    dma_read    = 5'd16,
    dma_write   = 5'd17   // last slot
  } ctr_idx_e;

  typedef enum logic {
    IDLE = 1'b0,
    SEND = 1'b1
  } dump_state_e;

endpackage

`default_nettype wire

//--- profiler/prof_event_counter.sv
// profiler event counter bank
// classifies each cycle's accepted cache operation, miss state and DMA
// packet strobes, and bumps one 32-bit wrapping counter per event class.
// all counters leave packed on ctr_flat_o, slot 0 in the low bits

`timescale 1ns/1ps
`default_nettype none

`include "prof_defs.svh"

module prof_event_counter (
  input  wire                                      clk_i,
  input  wire                                      reset_i,

  input  wire                                      op_v_i,
  input  wire                                      op_yumi_i,
  input  cache_op_pkg::cache_op_t                  op_code_i,
  input  cache_op_pkg::access_size_t               size_i,
  input  wire                                      sigext_i,
  input  cache_op_pkg::byte_mask_t                 mask_i,
  input  wire                                      miss_v_i,

  input  wire                                      dma_v_i,
  input  wire                                      dma_yumi_i,
  input  wire                                      dma_write_i,

  output logic [`PROF_NUM_CTRS*`PROF_CTR_W-1:0]   ctr_flat_o
);

  import cache_op_pkg::*;
  import prof_pkg::*;

  localparam int POP_W = $clog2(`PROF_MASK_W + 1);

  // number of bytes written by a store
  function automatic logic [POP_W-1:0] count_ones(input byte_mask_t m);
    logic [POP_W-1:0] n;
    n = '0;
    for (int b = 0; b < `PROF_MASK_W; b++) begin
      n = n + POP_W'(m[b]);
    end
    return n;
  endfunction

  logic                      accept;
  logic                      ld_acc;
  logic                      st_acc;
  logic                      ld_hit;
  logic                      st_hit;
  logic [POP_W-1:0]          mask_ones;
  logic                      dma_acc;
  logic [`PROF_NUM_CTRS-1:0] inc;

  ctr_t ctr_r [`PROF_NUM_CTRS];

  assign accept    = op_v_i & op_yumi_i;
  assign ld_acc    = accept & (op_code_i == ld);
  assign st_acc    = accept & (op_code_i == st);
  assign ld_hit    = ld_acc & ~miss_v_i;
  assign st_hit    = st_acc & ~miss_v_i;
  assign mask_ones = count_ones(mask_i);
  assign dma_acc   = dma_v_i & dma_yumi_i;

  // one increment pulse per counter slot
  always_comb begin
    inc = '0;

    inc[ld_total]    = ld_hit;
    inc[ld_word]     = ld_hit & (size_i == sz_word);
    inc[ld_half]     = ld_hit & (size_i == sz_half);
    inc[ld_byte]     = ld_hit & (size_i == sz_byte);
    inc[ld_unsigned] = ld_hit & ~sigext_i;

    // store size comes from the mask, odd masks only hit st_total
    inc[st_total]    = st_hit;
    inc[st_word]     = st_hit & (mask_ones == POP_W'(4));
    inc[st_half]     = st_hit & (mask_ones == POP_W'(2));
    inc[st_byte]     = st_hit & (mask_ones == POP_W'(1));

    // management ops count on acceptance, miss or not
    inc[tag_op]      = accept & (op_code_i inside {tagst, tagfl, taglv, tagla});
    inc[addr_op]     = accept & (op_code_i inside {afl, aflinv, ainv, alock, aunlock});
    inc[atomic_op]   = accept & (op_code_i inside {amoswap, amoor});

    inc[miss_ld]     = ld_acc & miss_v_i;
    inc[miss_st]     = st_acc & miss_v_i;
    inc[miss_cycle]  = miss_v_i;  // miss handler busy
    inc[idle_cycle]  = ~accept & ~miss_v_i;

    inc[dma_read]    = dma_acc & ~dma_write_i;
    inc[dma_write]   = dma_acc & dma_write_i;
  end

  // counters wrap at 2^32
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `PROF_NUM_CTRS; i++) begin
      if (reset_i) begin
        ctr_r[i] <= '0;
      end else if (inc[i]) begin
        ctr_r[i] <= ctr_r[i] + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `PROF_NUM_CTRS; i++) begin
      ctr_flat_o[i*`PROF_CTR_W +: `PROF_CTR_W] = ctr_r[i];
    end
  end

endmodule

`default_nettype wire

//--- profiler/prof_snapshot_fifo.sv
// snapshot FIFO
// small circular buffer of tagged counter snapshots between the counter
// bank and the dumper. a write into a full FIFO with no pop is discarded
// and flagged on dropped_o for one cycle

`timescale 1ns/1ps
`default_nettype none

`include "prof_defs.svh"

module prof_snapshot_fifo (
  input  wire                                      clk_i,
  input  wire                                      reset_i,

  input  wire                                      wr_v_i,
  input  prof_pkg::stat_tag_t                      wr_tag_i,
  input  wire [`PROF_NUM_CTRS*`PROF_CTR_W-1:0]     wr_flat_i,

  input  wire                                      rd_pop_i,
  output logic                                     rd_nonempty_o,
  output prof_pkg::stat_tag_t                      rd_tag_o,
  output logic [`PROF_NUM_CTRS*`PROF_CTR_W-1:0]   rd_flat_o,

  output logic                                     dropped_o
);

  import prof_pkg::*;

  localparam int DEPTH  = `PROF_FIFO_DEPTH;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int FLAT_W = `PROF_NUM_CTRS * `PROF_CTR_W;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  stat_tag_t          tag_mem  [DEPTH];
  logic [FLAT_W-1:0]  flat_mem [DEPTH];

  logic [PTR_W-1:0]   wr_ptr_r;
  logic [PTR_W-1:0]   rd_ptr_r;
  logic [CNT_W-1:0]   count_r;
  logic               full;
  logic               do_write;
  logic               dropped_r;

  assign full     = (count_r == CNT_W'(DEPTH));
  assign do_write = wr_v_i & (~full | rd_pop_i);  // a pop frees the slot in time

  // payload storage
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      tag_mem[wr_ptr_r]  <= wr_tag_i;
      flat_mem[wr_ptr_r] <= wr_flat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r  <= '0;
      rd_ptr_r  <= '0;
      count_r   <= '0;
      dropped_r <= 1'b0;
    end else begin
      if (do_write) wr_ptr_r <= next_ptr(wr_ptr_r);
      if (rd_pop_i) rd_ptr_r <= next_ptr(rd_ptr_r);
      case ({do_write, rd_pop_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // idle or pop and write together
      endcase
      dropped_r <= wr_v_i & full & ~rd_pop_i;
    end
  end

  assign rd_nonempty_o = (count_r != '0);
  assign rd_tag_o      = tag_mem[rd_ptr_r];
  assign rd_flat_o     = flat_mem[rd_ptr_r];
  assign dropped_o     = dropped_r;

endmodule

`default_nettype wire

//--- profiler/prof_stat_dumper.sv
// stat dumper
// takes one snapshot at a time out of the snapshot FIFO into a holding
// register and streams it out one counter per cycle, index 0 first.
// no back-pressure on the dump port

`timescale 1ns/1ps
`default_nettype none

`include "prof_defs.svh"

module prof_stat_dumper (
  input  wire                                      clk_i,
  input  wire                                      reset_i,

  input  wire                                      rd_nonempty_i,
  input  prof_pkg::stat_tag_t                      rd_tag_i,
  input  wire [`PROF_NUM_CTRS*`PROF_CTR_W-1:0]     rd_flat_i,
  output logic                                     rd_pop_o,

  output logic                                     dump_v_o,
  output prof_pkg::stat_tag_t                      dump_tag_o,
  output prof_pkg::ctr_idx_e                       dump_idx_o,
  output prof_pkg::ctr_t                           dump_value_o
);

  import prof_pkg::*;

  localparam int FLAT_W = `PROF_NUM_CTRS * `PROF_CTR_W;
  localparam ctr_idx_e LAST_IDX = ctr_idx_e'(`PROF_NUM_CTRS - 1);

  dump_state_e        state_r;
  ctr_idx_e           idx_r;
  stat_tag_t          tag_r;
  logic [FLAT_W-1:0]  flat_r;

  // pop whenever idle and something is queued
  assign rd_pop_o = (state_r == IDLE) & rd_nonempty_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      idx_r   <= ld_total;
    end else begin
      case (state_r)
        IDLE: begin
          if (rd_nonempty_i) begin
            state_r <= SEND;
            idx_r   <= ld_total;
          end
        end
        SEND: begin
          if (idx_r == LAST_IDX) begin
            state_r <= IDLE;  // next entry waits one cycle
          end else begin
            idx_r <= ctr_idx_e'(idx_r + 1'b1);
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  // holding copy, FIFO slot is released by the pop
  always_ff @(posedge clk_i) begin
    if (rd_pop_o) begin
      tag_r  <= rd_tag_i;
      flat_r <= rd_flat_i;
    end
  end

  assign dump_v_o     = (state_r == SEND);
  assign dump_tag_o   = tag_r;
  assign dump_idx_o   = idx_r;
  assign dump_value_o = flat_r[int'(idx_r)*`PROF_CTR_W +: `PROF_CTR_W];

endmodule

`default_nettype wire

//--- src/cache_profiler_top.sv
// cache profiler top
// counter bank feeds the snapshot FIFO on each print strobe, and the
// dumper drains the FIFO onto the dump port

`timescale 1ns/1ps
`default_nettype none

`include "prof_defs.svh"

module cache_profiler_top (
  input  wire                         clk_i,
  input  wire                         reset_i,

  // cache side
  input  wire                         op_v_i,
  input  wire                         op_yumi_i,
  input  cache_op_pkg::cache_op_t     op_code_i,
  input  cache_op_pkg::access_size_t  size_i,
  input  wire                         sigext_i,
  input  cache_op_pkg::byte_mask_t    mask_i,
  input  wire                         miss_v_i,
  input  wire                         dma_v_i,
  input  wire                         dma_yumi_i,
  input  wire                         dma_write_i,

  // snapshot request
  input  wire                         print_stat_v_i,
  input  prof_pkg::stat_tag_t         print_stat_tag_i,

  output logic                        dump_v_o,
  output prof_pkg::stat_tag_t         dump_tag_o,
  output prof_pkg::ctr_idx_e          dump_idx_o,
  output prof_pkg::ctr_t              dump_value_o,
  output logic                        dropped_o
);

  import prof_pkg::*;

  logic [`PROF_NUM_CTRS*`PROF_CTR_W-1:0] ctr_flat;
  logic [`PROF_NUM_CTRS*`PROF_CTR_W-1:0] fifo_flat;
  stat_tag_t                             fifo_tag;
  logic                                  fifo_nonempty;
  logic                                  fifo_pop;

  prof_event_counter counter_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .op_v_i      (op_v_i),
    .op_yumi_i   (op_yumi_i),
    .op_code_i   (op_code_i),
    .size_i      (size_i),
    .sigext_i    (sigext_i),
    .mask_i      (mask_i),
    .miss_v_i    (miss_v_i),
    .dma_v_i     (dma_v_i),
    .dma_yumi_i  (dma_yumi_i),
    .dma_write_i (dma_write_i),
    .ctr_flat_o  (ctr_flat)
  );

  // snapshot holds the counts as registered before the print edge
  prof_snapshot_fifo fifo_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wr_v_i        (print_stat_v_i),
    .wr_tag_i      (print_stat_tag_i),
    .wr_flat_i     (ctr_flat),
    .rd_pop_i      (fifo_pop),
    .rd_nonempty_o (fifo_nonempty),
    .rd_tag_o      (fifo_tag),
    .rd_flat_o     (fifo_flat),
    .dropped_o     (dropped_o)
  );

  prof_stat_dumper dumper_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_nonempty_i (fifo_nonempty),
    .rd_tag_i      (fifo_tag),
    .rd_flat_i     (fifo_flat),
    .rd_pop_o      (fifo_pop),
    .dump_v_o      (dump_v_o),
    .dump_tag_o    (dump_tag_o),
    .dump_idx_o    (dump_idx_o),
    .dump_value_o  (dump_value_o)
  );

endmodule

`default_nettype wire

//--- dv/cache_profiler_tb.sv
// cache profiler testbench
// replays a per-cycle trace of cache, DMA and print activity into the
// profiler, collects the dump stream and the dropped pulses, and checks
// them against the snapshots listed in the trace

`timescale 1ns/1ps
`default_nettype none

`include "prof_defs.svh"

module cache_profiler_tb;

  import cache_op_pkg::*;
  import prof_pkg::*;

  localparam int    NUM_CTRS    = `PROF_NUM_CTRS;
  localparam int    WAIT_CYCLES = 200;
  localparam string TRACE_FILE  = "dv/prof_trace.txt";

  // one trace cycle line
  typedef struct packed {
    logic                   op_v;
    logic                   op_yumi;
    logic [3:0]             op_code;
    logic [1:0]             size;
    logic                   sigext;
    logic [`PROF_MASK_W-1:0] mask;
    logic                   miss_v;
    logic                   dma_v;
    logic                   dma_yumi;
    logic                   dma_write;
    logic                   print_v;
    logic [`PROF_TAG_W-1:0] print_tag;
  } cycle_t;

  logic         clk_i;
  logic         reset_i;
  logic         op_v_i;
  logic         op_yumi_i;
  cache_op_t    op_code_i;
  access_size_t size_i;
  logic         sigext_i;
  byte_mask_t   mask_i;
  logic         miss_v_i;
  logic         dma_v_i;
  logic         dma_yumi_i;
  logic         dma_write_i;
  logic         print_stat_v_i;
  stat_tag_t    print_stat_tag_i;

  logic         dump_v_o;
  stat_tag_t    dump_tag_o;
  ctr_idx_e     dump_idx_o;
  ctr_t         dump_value_o;
  logic         dropped_o;

  cycle_t    stim_q[$];
  stat_tag_t exp_tag_q[$];
  ctr_t      exp_val_q[$];  // NUM_CTRS words per expected dump
  int        exp_drops;
  int        dumps_seen;
  int        word_pos;
  int        drops_seen;

  cache_profiler_top dut_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .op_v_i           (op_v_i),
    .op_yumi_i        (op_yumi_i),
    .op_code_i        (op_code_i),
    .size_i           (size_i),
    .sigext_i         (sigext_i),
    .mask_i           (mask_i),
    .miss_v_i         (miss_v_i),
    .dma_v_i          (dma_v_i),
    .dma_yumi_i       (dma_yumi_i),
    .dma_write_i      (dma_write_i),
    .print_stat_v_i   (print_stat_v_i),
    .print_stat_tag_i (print_stat_tag_i),
    .dump_v_o         (dump_v_o),
    .dump_tag_o       (dump_tag_o),
    .dump_idx_o       (dump_idx_o),
    .dump_value_o     (dump_value_o),
    .dropped_o        (dropped_o)
  );

  always #4 clk_i = ~clk_i;  // 8 ns period

  task automatic abort_sim();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h",
               $time, what, got, expected);
      abort_sim();
    end
  endtask

  task automatic load_trace();
    int     fd;
    int     n;
    string  line;
    byte    kind;
    int     f [19];
    cycle_t c;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open trace file %s", TRACE_FILE);
      abort_sim();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0) continue;
      kind = line.getc(0);
      if (kind == "C") begin
        n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5],
                    f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n != 12) begin
          $display("malformed cycle line in trace: %s", line);
          abort_sim();
        end
        c.op_v      = f[0][0];
        c.op_yumi   = f[1][0];
        c.op_code   = 4'(f[2]);
        c.size      = 2'(f[3]);
        c.sigext    = f[4][0];
        c.mask      = `PROF_MASK_W'(f[5]);
        c.miss_v    = f[6][0];
        c.dma_v     = f[7][0];
        c.dma_yumi  = f[8][0];
        c.dma_write = f[9][0];
        c.print_v   = f[10][0];
        c.print_tag = `PROF_TAG_W'(f[11]);
        stim_q.push_back(c);
      end else if (kind == "D") begin
        n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
        if (n != NUM_CTRS + 1) begin
          $display("malformed dump line in trace: %s", line);
          abort_sim();
        end
        exp_tag_q.push_back(stat_tag_t'(f[0]));
        for (int i = 1; i <= NUM_CTRS; i++) begin
          exp_val_q.push_back(ctr_t'(f[i]));
        end
      end else if (kind == "X") begin
        exp_drops++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_cycle(input cycle_t c);
    op_v_i           <= c.op_v;
    op_yumi_i        <= c.op_yumi;
    op_code_i        <= cache_op_t'(c.op_code);
    size_i           <= access_size_t'(c.size);
    sigext_i         <= c.sigext;
    mask_i           <= c.mask;
    miss_v_i         <= c.miss_v;
    dma_v_i          <= c.dma_v;
    dma_yumi_i       <= c.dma_yumi;
    dma_write_i      <= c.dma_write;
    print_stat_v_i   <= c.print_v;
    print_stat_tag_i <= c.print_tag;
  endtask

  // one word of the dump stream, checked in arrival order
  task automatic collect_word();
    int base;
    if (dumps_seen >= exp_tag_q.size()) begin
      $display("unexpected dump word with tag 0x%02h at %0t ns", dump_tag_o, $time);
      abort_sim();
    end else begin
      base = dumps_seen * NUM_CTRS;
      check_value("dump index", 32'(dump_idx_o), 32'(word_pos));
      check_value("dump tag", 32'(dump_tag_o), 32'(exp_tag_q[dumps_seen]));
      check_value($sformatf("dump %0d counter %0d", dumps_seen, word_pos),
                  dump_value_o, exp_val_q[base + word_pos]);
      word_pos++;
      if (word_pos == NUM_CTRS) begin
        word_pos = 0;
        dumps_seen++;
      end
    end
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (dropped_o) drops_seen++;
      if (dump_v_o) begin
        collect_word();
      end else if (word_pos != 0) begin
        $display("dump stream broke off after %0d words", word_pos);
        abort_sim();
      end
    end
  end

  task automatic wait_for_dumps();
    int cycles;
    cycles = 0;
    while (dumps_seen < exp_tag_q.size()) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_CYCLES) begin
        $display("timeout waiting for dump %0d of %0d", dumps_seen + 1, exp_tag_q.size());
        abort_sim();
      end
    end
  endtask

  task automatic wait_for_drops();
    int cycles;
    cycles = 0;
    while (drops_seen < exp_drops) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_CYCLES) begin
        $display("timeout waiting for dropped pulse %0d of %0d", drops_seen + 1, exp_drops);
        abort_sim();
      end
    end
  endtask

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    op_v_i           = 1'b0;
    op_yumi_i        = 1'b0;
    op_code_i        = ld;
    size_i           = sz_byte;
    sigext_i         = 1'b0;
    mask_i           = '0;
    miss_v_i         = 1'b0;
    dma_v_i          = 1'b0;
    dma_yumi_i       = 1'b0;
    dma_write_i      = 1'b0;
    print_stat_v_i   = 1'b0;
    print_stat_tag_i = '0;
    exp_drops        = 0;
    dumps_seen       = 0;
    word_pos         = 0;
    drops_seen       = 0;

    load_trace();

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;  // first trace cycle goes out on the same edge
    foreach (stim_q[i]) begin
      drive_cycle(stim_q[i]);
      @(posedge clk_i);
    end
    drive_cycle('0);

    wait_for_dumps();
    wait_for_drops();
    repeat (NUM_CTRS + 2) @(posedge clk_i);  // quiet period, catches stray dumps
    check_value("dropped pulse count", drops_seen, exp_drops);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/prof_trace.txt
# C op_v op_yumi op_code size sigext mask miss_v dma_v dma_yumi dma_write print_v print_tag
# D tag ctr0..ctr17 is one expected dump, X is one expected dropped pulse, all fields hex
# loads: word signed, half unsigned, byte unsigned, byte signed, load under miss, not accepted
C 1 1 0 2 1 0 0 0 0 0 0 00
C 1 1 0 1 0 0 0 0 0 0 0 00
C 1 1 0 0 0 0 0 0 0 0 0 00
C 1 1 0 0 1 0 0 0 0 0 0 00
C 1 1 0 2 0 0 1 0 0 0 0 00
C 1 0 0 2 0 0 0 0 0 0 0 00
# stores: masks with 4, 2, 1 and 3 bits, then a store under miss
C 1 1 1 2 0 f 0 0 0 0 0 00
C 1 1 1 2 0 3 0 0 0 0 0 00
C 1 1 1 2 0 4 0 0 0 0 0 00
C 1 1 1 2 0 7 0 0 0 0 0 00
C 1 1 1 2 0 c 1 0 0 0 0 00
C 0 0 0 0 0 0 1 0 0 0 0 00
# tag, address and atomic ops with DMA traffic
C 1 1 2 0 0 0 0 1 1 0 0 00
C 1 1 4 0 0 0 1 1 0 1 0 00
C 1 1 6 0 0 0 0 1 1 1 0 00
C 1 1 a 0 0 0 0 0 0 0 0 00
C 1 1 b 0 0 0 0 0 0 0 0 00
C 1 1 c 0 0 0 0 1 1 0 0 00
# print 11 with a load in the same cycle, excluded from dump 11
C 1 1 0 2 1 0 0 0 0 0 1 11
C 0 0 0 0 0 0 0 1 1 1 0 00
# prints 22, 33, 44 while the dumper is busy, 44 is dropped
C 1 1 1 2 0 1 0 0 0 0 1 22
C 1 1 9 0 0 0 0 0 0 0 1 33
C 0 0 0 0 0 0 1 0 0 0 1 44
C 0 0 0 0 0 0 0 0 0 0 0 00
# expected dumps in order
D 11 4 1 1 2 2 4 1 1 1 2 2 2 1 1 4 1 2 1
D 22 5 2 1 2 2 4 1 1 1 2 2 2 1 1 4 2 2 2
D 33 5 2 1 2 2 5 1 1 2 2 2 2 1 1 4 2 2 2
X

//--- filelist.f
+incdir+common
common/cache_op_pkg.sv
common/prof_pkg.sv
profiler/prof_event_counter.sv
profiler/prof_snapshot_fifo.sv
profiler/prof_stat_dumper.sv
src/cache_profiler_top.sv
dv/cache_profiler_tb.sv

//--- Makefile
# Verilator build and run for the cache profiler testbench
# run from the project root so the trace path resolves

VERILATOR ?= verilator
TOP       ?= cache_profiler_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@grep -qx 'TESTS PASSED' $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
